// File: Bender.yml
package:
  name: jump_character

sources:
  - files:
      - rtl/jump_pkg.sv
      - rtl/frame_tick_gen.sv
      - rtl/command_decoder.sv
      - rtl/character_motion.sv
      - rtl/character_display.sv
      - rtl/jump_character_top.sv
  - target: simulation
    files:
      - verification/tb_jump_character.sv

// File: all.f
rtl/jump_pkg.sv
rtl/frame_tick_gen.sv
rtl/command_decoder.sv
rtl/character_motion.sv
rtl/character_display.sv
rtl/jump_character_top.sv
verification/tb_jump_character.sv

// File: rtl/character_display.sv
`timescale 1ns/1ps

module character_display #(
    parameter int PHY_WIDTH    = 15,
    parameter int RATE_WIDTH   = 6,
    parameter int REFRESH_RATE = 32
) (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  logic                        frame_tick,
    input  jump_pkg::char_state_e       char_state,
    input  logic signed [PHY_WIDTH-1:0] vel_y,
    output jump_pkg::display_id_e       char_display_id
);

    localparam logic [RATE_WIDTH-1:0] IDLE_BREATHE_TIME   = RATE_WIDTH'(REFRESH_RATE / 2);
    localparam logic [RATE_WIDTH-1:0] FALL_TO_GROUND_TIME = RATE_WIDTH'(REFRESH_RATE);
    localparam logic [RATE_WIDTH-1:0] RATE_LAST           = RATE_WIDTH'(REFRESH_RATE - 1);

    logic                        frame_tick_d;
    jump_pkg::char_state_e       char_state_d;
    logic signed [PHY_WIDTH-1:0] vel_y_d;
    jump_pkg::display_id_e       display_state;
    jump_pkg::display_id_e       next_display_state;
    logic [RATE_WIDTH-1:0]       idle_cnt;
    logic [RATE_WIDTH-1:0]       fall_cnt;

    // ====================
    // Input delay stage
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            frame_tick_d <= 1'b0;
            char_state_d <= jump_pkg::IDLE;
            vel_y_d      <= '0;
        end else begin
            frame_tick_d <= frame_tick;
            char_state_d <= char_state;
            vel_y_d      <= vel_y;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            display_state <= jump_pkg::IDLE_DIS_1;
        end else if (frame_tick_d) begin
            display_state <= next_display_state;
        end
    end

    // ====================
    // Sprite selection
    always_comb begin
        case (char_state_d)
            jump_pkg::IDLE: begin
                if (display_state == jump_pkg::FALL_TO_GROUND_DIS &&
                    fall_cnt < FALL_TO_GROUND_TIME - 1'b1) begin
                    next_display_state = jump_pkg::FALL_TO_GROUND_DIS;   // Landing hold
                end else if (vel_y_d > 0) begin
                    next_display_state = jump_pkg::JUMP_UP_DIS;
                end else if (vel_y_d < 0) begin
                    next_display_state = jump_pkg::JUMP_DOWN_DIS;
                end else begin
                    next_display_state = (idle_cnt < IDLE_BREATHE_TIME) ?
                                         jump_pkg::IDLE_DIS_1 : jump_pkg::IDLE_DIS_2;
                end
            end
            jump_pkg::CHARGE:         next_display_state = jump_pkg::CHARGE_DIS;
            jump_pkg::FALL_TO_GROUND: next_display_state = jump_pkg::FALL_TO_GROUND_DIS;
            default:                  next_display_state = jump_pkg::IDLE_DIS_1;
        endcase
    end

    assign char_display_id = display_state;

    // Breathing counter, free running
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            idle_cnt <= '0;
        end else if (frame_tick_d) begin
            idle_cnt <= (idle_cnt == RATE_LAST) ? '0 : idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            fall_cnt <= '0;
        end else if (frame_tick_d) begin
            fall_cnt <= (display_state == jump_pkg::FALL_TO_GROUND_DIS) ? fall_cnt + 1'b1 : '0;
        end
    end

    a_sprite_legal : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        3'(char_display_id) <= 3'd5
    ) else $error("sprite id took an unused code");

endmodule

// File: rtl/character_motion.sv
`timescale 1ns/1ps

module character_motion #(
    parameter int PHY_WIDTH  = 15,
    parameter int MAX_CHARGE = 12
) (
    input  logic                                sys_clk,
    input  logic                                sys_rst_n,
    input  logic                                frame_tick,
    input  logic                                btn_left,
    input  logic                                btn_right,
    input  logic                                btn_jump,
    output jump_pkg::char_state_e               char_state,
    output logic signed [PHY_WIDTH-1:0]         vel_y,
    output logic signed [PHY_WIDTH-1:0]         pos_y,
    output logic [jump_pkg::POS_X_WIDTH-1:0]    pos_x
);

    localparam int CHARGE_WIDTH = $clog2(MAX_CHARGE + 1);

    logic [CHARGE_WIDTH-1:0]     charge;
    logic                        airborne;
    logic signed [PHY_WIDTH-1:0] pos_y_next;
    logic                        landing;
    logic                        charge_full;

    // Height after this tick's velocity step
    assign pos_y_next  = pos_y + vel_y;
    assign landing     = (pos_y_next <= 0);
    assign charge_full = (charge >= CHARGE_WIDTH'(MAX_CHARGE));

    // ====================
    // Airborne flight
    // Buttons are not looked at until the character lands
    // ====================
    // Grounded control
    // Jump has priority over walking, release of a charge launches
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_state <= jump_pkg::IDLE;
            charge     <= '0;
            airborne   <= 1'b0;
            vel_y      <= '0;
            pos_y      <= '0;
            pos_x      <= '0;
        end else if (frame_tick) begin
            if (airborne) begin
                if (landing) begin
                    pos_y      <= '0;
                    vel_y      <= '0;
                    airborne   <= 1'b0;
                    char_state <= jump_pkg::FALL_TO_GROUND;   // One tick only
                end else begin
                    pos_y      <= pos_y_next;
                    vel_y      <= vel_y - 1;   // Gravity
                    char_state <= jump_pkg::IDLE;
                end
            end else if (btn_jump) begin
                char_state <= jump_pkg::CHARGE;
                if (!charge_full) begin
                    charge <= charge + 1'b1;
                end
            end else if (char_state == jump_pkg::CHARGE) begin
                char_state <= jump_pkg::JUMP;
                vel_y      <= PHY_WIDTH'(charge);   // Launch speed from charge
                charge     <= '0;
                airborne   <= 1'b1;
            end else if (btn_right) begin
                char_state <= jump_pkg::RIGHT;
                pos_x      <= pos_x + 1'b1;
            end else if (btn_left) begin
                char_state <= jump_pkg::LEFT;
                pos_x      <= pos_x - 1'b1;
            end else begin
                char_state <= jump_pkg::IDLE;
            end
        end
    end

    // Height is clamped at the ground on every landing
    a_pos_y_nonneg : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        pos_y >= 0
    ) else $error("pos_y went below ground");

endmodule

// File: rtl/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       cmd_req,
    input  logic [2:0] cmd_code,
    output logic       cmd_ack,
    output logic       cmd_err,
    output logic       btn_left,
    output logic       btn_right,
    output logic       btn_jump
);

    logic cmd_take;
    logic cmd_done;

    assign cmd_take = cmd_req && !cmd_ack;   // New request, code is stable
    assign cmd_done = cmd_ack && !cmd_req;   // Host has dropped req

    // ====================
    // Four-phase slave and held button levels
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cmd_ack   <= 1'b0;
            cmd_err   <= 1'b0;
            btn_left  <= 1'b0;
            btn_right <= 1'b0;
            btn_jump  <= 1'b0;
        end else if (cmd_take) begin
            cmd_ack <= 1'b1;
            cmd_err <= 1'b0;
            case (cmd_code)
                jump_pkg::PRESS_LEFT: begin
                    btn_left  <= 1'b1;
                    btn_right <= 1'b0;   // Only one direction at a time
                end
                jump_pkg::RELEASE_LEFT: begin
                    btn_left <= 1'b0;
                end
                jump_pkg::PRESS_RIGHT: begin
                    btn_right <= 1'b1;
                    btn_left  <= 1'b0;
                end
                jump_pkg::RELEASE_RIGHT: begin
                    btn_right <= 1'b0;
                end
                jump_pkg::PRESS_JUMP: begin
                    btn_jump <= 1'b1;
                end
                jump_pkg::RELEASE_JUMP: begin
                    btn_jump <= 1'b0;
                end
                default: begin
                    cmd_err <= 1'b1;   // Acked anyway, buttons kept
                end
            endcase
        end else if (cmd_done) begin
            cmd_ack <= 1'b0;
        end
    end

    // Ack only answers a live request
    a_ack_after_req : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(cmd_ack) |-> $past(cmd_req)
    ) else $error("cmd_ack rose without cmd_req");

    a_one_direction : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !(btn_left && btn_right)
    ) else $error("left and right held together");

endmodule

// File: rtl/frame_tick_gen.sv
`timescale 1ns/1ps

module frame_tick_gen #(
    parameter int TICK_DIV = 4
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic frame_tick
);

    localparam int CNT_WIDTH = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_WIDTH-1:0] RELOAD = CNT_WIDTH'(TICK_DIV - 1);

    logic [CNT_WIDTH-1:0] div_cnt;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt    <= RELOAD;
            frame_tick <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt    <= RELOAD;
            frame_tick <= 1'b1;   // One cycle per frame
        end else begin
            div_cnt    <= div_cnt - 1'b1;
            frame_tick <= 1'b0;
        end
    end

    // Tick is a single-cycle enable unless the divider is bypassed
    a_tick_single : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (frame_tick && TICK_DIV > 1) |=> !frame_tick
    ) else $error("frame_tick high on two cycles in a row");

endmodule

// File: rtl/jump_character_top.sv
`timescale 1ns/1ps

module jump_character_top #(
    parameter int TICK_DIV     = 4,
    parameter int PHY_WIDTH    = 15,
    parameter int RATE_WIDTH   = 6,
    parameter int REFRESH_RATE = 32,
    parameter int MAX_CHARGE   = 12
) (
    input  logic                             sys_clk,
    input  logic                             sys_rst_n,
    input  logic                             cmd_req,
    input  logic [2:0]                       cmd_code,
    output logic                             cmd_ack,
    output logic                             cmd_err,
    output jump_pkg::char_state_e            char_state,
    output jump_pkg::display_id_e            char_display_id,
    output logic [jump_pkg::POS_X_WIDTH-1:0] pos_x,
    output logic signed [PHY_WIDTH-1:0]      pos_y,
    output logic                             frame_tick
);

    logic                        btn_left;
    logic                        btn_right;
    logic                        btn_jump;
    logic signed [PHY_WIDTH-1:0] vel_y;

    frame_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) frame_tick_gen_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_tick (frame_tick)
    );

    // Decode stage
    command_decoder command_decoder_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cmd_req   (cmd_req),
        .cmd_code  (cmd_code),
        .cmd_ack   (cmd_ack),
        .cmd_err   (cmd_err),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump)
    );

    // Execute stage
    character_motion #(
        .PHY_WIDTH  (PHY_WIDTH),
        .MAX_CHARGE (MAX_CHARGE)
    ) character_motion_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_tick (frame_tick),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_jump   (btn_jump),
        .char_state (char_state),
        .vel_y      (vel_y),
        .pos_y      (pos_y),
        .pos_x      (pos_x)
    );

    // Result stage
    character_display #(
        .PHY_WIDTH    (PHY_WIDTH),
        .RATE_WIDTH   (RATE_WIDTH),
        .REFRESH_RATE (REFRESH_RATE)
    ) character_display_i (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .frame_tick      (frame_tick),
        .char_state      (char_state),
        .vel_y           (vel_y),
        .char_display_id (char_display_id)
    );

endmodule

// File: rtl/jump_pkg.sv
package jump_pkg;

    // Horizontal position width, wraps at the edge of the field
    localparam int POS_X_WIDTH = 10;
    localparam int CMD_WIDTH   = 3;

    // ====================
    // Character motion state
    typedef enum logic [2:0] {
        IDLE           = 3'd0,
        LEFT           = 3'd1,
        RIGHT          = 3'd2,
        CHARGE         = 3'd3,
        JUMP           = 3'd4,
        COLLISION      = 3'd5,   // Reserved, no walls yet
        FALL_TO_GROUND = 3'd6,
        HOLD           = 3'd7    // Reserved
    } char_state_e;

    // ====================
    // Sprite shown on screen
    typedef enum logic [2:0] {
        IDLE_DIS_1         = 3'd0,
        IDLE_DIS_2         = 3'd1,
        CHARGE_DIS         = 3'd2,
        JUMP_UP_DIS        = 3'd3,
        JUMP_DOWN_DIS      = 3'd4,
        FALL_TO_GROUND_DIS = 3'd5
    } display_id_e;

    // ====================
    // Host button events, codes 6 and 7 are illegal
    typedef enum logic [CMD_WIDTH-1:0] {
        PRESS_LEFT    = 3'd0,
        RELEASE_LEFT  = 3'd1,
        PRESS_RIGHT   = 3'd2,
        RELEASE_RIGHT = 3'd3,
        PRESS_JUMP    = 3'd4,
        RELEASE_JUMP  = 3'd5
    } cmd_code_e;

endpackage

// File: verification/tb_jump_character.sv
`timescale 1ns/1ps

module tb_jump_character;

    localparam int TICK_DIV     = 4;
    localparam int PHY_WIDTH    = 15;
    localparam int RATE_WIDTH   = 6;
    localparam int REFRESH_RATE = 32;
    localparam int MAX_CHARGE   = 12;
    localparam int HS_LIMIT     = 20;     // Cycles allowed per handshake step
    localparam int TEST_TICKS   = 1000;   // Rough sum of frame ticks over all tests
    localparam real WATCHDOG_NS = TEST_TICKS * TICK_DIV * 100.0 * 2.0;

    logic                             sys_clk;
    logic                             sys_rst_n;
    logic                             cmd_req;
    logic [2:0]                       cmd_code;
    logic                             cmd_ack;
    logic                             cmd_err;
    jump_pkg::char_state_e            char_state;
    jump_pkg::display_id_e            char_display_id;
    logic [jump_pkg::POS_X_WIDTH-1:0] pos_x;
    logic signed [PHY_WIDTH-1:0]      pos_y;
    logic                             frame_tick;

    int          errors;
    int          checks;
    logic [31:0] rng_state;
    logic        tick_prev;
    int          charge_cnt;
    int          right_cnt;
    int          left_cnt;
    int          tick_gap;
    logic        tick_seen;

    jump_character_top #(
        .TICK_DIV     (TICK_DIV),
        .PHY_WIDTH    (PHY_WIDTH),
        .RATE_WIDTH   (RATE_WIDTH),
        .REFRESH_RATE (REFRESH_RATE),
        .MAX_CHARGE   (MAX_CHARGE)
    ) jump_character_top_i (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .cmd_req         (cmd_req),
        .cmd_code        (cmd_code),
        .cmd_ack         (cmd_ack),
        .cmd_err         (cmd_err),
        .char_state      (char_state),
        .char_display_id (char_display_id),
        .pos_x           (pos_x),
        .pos_y           (pos_y),
        .frame_tick      (frame_tick)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // ====================
    // Counts motion updates per state, sampled one cycle after each tick
    always @(negedge sys_clk) begin
        if (tick_prev) begin
            if (char_state == jump_pkg::CHARGE) charge_cnt++;
            if (char_state == jump_pkg::RIGHT)  right_cnt++;
            if (char_state == jump_pkg::LEFT)   left_cnt++;
        end
        // Tick spacing in cycles
        if (frame_tick) begin
            if (tick_seen) compare_value("frame_tick period", tick_gap, TICK_DIV);
            tick_seen = 1'b1;
            tick_gap  = 0;
        end
        tick_gap++;
        tick_prev = frame_tick;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic wait_ticks(input int n);
        repeat (n) begin
            @(negedge sys_clk);
            while (!frame_tick) @(negedge sys_clk);
        end
    endtask

    task automatic send_cmd(input logic [2:0] code);
        int n;
        @(posedge sys_clk);
        cmd_code <= code;
        cmd_req  <= 1'b1;
        n = 0;
        @(negedge sys_clk);
        while (!cmd_ack && n < HS_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (!cmd_ack) report_failure($sformatf("cmd_ack never rose for code %0d", code));
        @(posedge sys_clk);
        cmd_req <= 1'b0;
        n = 0;
        @(negedge sys_clk);
        while (cmd_ack && n < HS_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (cmd_ack) report_failure("cmd_ack stayed high after cmd_req dropped");
    endtask

    // Waits for the ground and the end of any landing hold
    task automatic settle();
        wait_ticks(2 * REFRESH_RATE + 4);
    endtask

    // ====================
    // Directed tests
    task automatic verify_reset_state();
        int n;
        @(negedge sys_clk);
        compare_value("cmd_ack", cmd_ack, 0);
        compare_value("cmd_err", cmd_err, 0);
        compare_value("char_state", char_state, jump_pkg::IDLE);
        compare_value("pos_x", pos_x, 0);
        compare_value("pos_y", pos_y, 0);
        compare_value("char_display_id", char_display_id, jump_pkg::IDLE_DIS_1);
        // First frame tick comes TICK_DIV cycles after reset release
        n = 0;
        while (!frame_tick && n < 4 * TICK_DIV) begin
            @(negedge sys_clk);
            n++;
        end
        compare_value("first frame_tick delay", n, TICK_DIV);
    endtask

    task automatic handshake_and_bad_codes();
        logic [2:0] codes [8] = '{3'd0, 3'd6, 3'd1, 3'd7, 3'd2, 3'd3, 3'd4, 3'd5};
        foreach (codes[i]) begin
            send_cmd(codes[i]);
            compare_value("cmd_err", cmd_err, (codes[i] >= 3'd6) ? 1 : 0);
        end
        settle();
    endtask

    task automatic walk_direction(input logic go_right);
        int n;
        logic [jump_pkg::POS_X_WIDTH-1:0] x0;
        rng_state = lcg_next(rng_state);
        n = 3 + int'(rng_state[23:16] % 18);
        x0 = pos_x;
        right_cnt = 0;
        left_cnt  = 0;
        send_cmd(go_right ? jump_pkg::PRESS_RIGHT : jump_pkg::PRESS_LEFT);
        wait_ticks(n);
        send_cmd(go_right ? jump_pkg::RELEASE_RIGHT : jump_pkg::RELEASE_LEFT);
        wait_ticks(2);
        if (go_right) begin
            if (right_cnt < n) report_failure("too few ticks spent walking right");
            compare_value("pos_x", pos_x, jump_pkg::POS_X_WIDTH'(x0 + right_cnt));
        end else begin
            if (left_cnt < n) report_failure("too few ticks spent walking left");
            compare_value("pos_x", pos_x, jump_pkg::POS_X_WIDTH'(x0 - left_cnt));
        end
    endtask

    task automatic charge_and_jump(input int k);
        int v;
        int n;
        int peak;
        logic up_seen;
        logic down_seen;
        charge_cnt = 0;
        up_seen    = 1'b0;
        down_seen  = 1'b0;
        send_cmd(jump_pkg::PRESS_JUMP);
        wait_ticks(k);
        compare_value("char_display_id", char_display_id, jump_pkg::CHARGE_DIS);
        send_cmd(jump_pkg::RELEASE_JUMP);
        n = 0;
        while (pos_y == 0 && n < 8 * TICK_DIV) begin
            @(negedge sys_clk);
            n++;
        end
        if (pos_y == 0) report_failure("character never left the ground");
        if (charge_cnt < k || charge_cnt > k + 1) report_failure("charge tick count off");
        v = (charge_cnt < MAX_CHARGE) ? charge_cnt : MAX_CHARGE;
        compare_value("pos_y", pos_y, v);   // First flight step is the launch speed
        peak = 0;
        n = 0;
        while (pos_y != 0 && n < 200 * TICK_DIV) begin
            if (pos_y > peak) peak = pos_y;
            if (char_display_id == jump_pkg::JUMP_DOWN_DIS) down_seen = 1'b1;
            if (char_display_id == jump_pkg::JUMP_UP_DIS) begin
                up_seen = 1'b1;
                if (down_seen) report_failure("rising sprite shown after falling sprite");
            end
            @(negedge sys_clk);
            n++;
        end
        if (pos_y != 0) report_failure("character never landed");
        compare_value("peak pos_y", peak, v * (v + 1) / 2);
        if (!up_seen) report_failure("rising sprite never shown");
        if (!down_seen) report_failure("falling sprite never shown");
        // Landing hold
        n = 0;
        while (char_display_id != jump_pkg::FALL_TO_GROUND_DIS && n < 4 * TICK_DIV) begin
            @(negedge sys_clk);
            n++;
        end
        if (char_display_id != jump_pkg::FALL_TO_GROUND_DIS) begin
            report_failure("landing sprite never shown");
        end
        n = 0;
        while (char_display_id == jump_pkg::FALL_TO_GROUND_DIS && n < 2 * REFRESH_RATE) begin
            wait_ticks(1);
            n++;
        end
        if (n < REFRESH_RATE - 1 || n > REFRESH_RATE + 1) begin
            report_failure($sformatf("landing sprite held %0d ticks", n));
        end
        @(negedge sys_clk);
        if (char_display_id != jump_pkg::IDLE_DIS_1 && char_display_id != jump_pkg::IDLE_DIS_2)
            report_failure("no idle sprite after landing");
        settle();
    endtask

    task automatic idle_breathing();
        jump_pkg::display_id_e prev;
        int n;
        prev = char_display_id;
        n = 0;
        while (char_display_id == prev && n < 2 * REFRESH_RATE) begin
            wait_ticks(1);
            n++;
        end
        repeat (3) begin
            prev = char_display_id;
            n = 0;
            while (char_display_id == prev && n < 2 * REFRESH_RATE) begin
                wait_ticks(1);
                n++;
            end
            if (n < REFRESH_RATE / 2 - 1 || n > REFRESH_RATE / 2 + 1) begin
                report_failure($sformatf("breathing sprite changed after %0d ticks", n));
            end
            if (char_display_id != jump_pkg::IDLE_DIS_1 &&
                char_display_id != jump_pkg::IDLE_DIS_2) begin
                report_failure("non idle sprite while breathing");
            end
        end
    endtask

    task automatic air_control();
        logic [jump_pkg::POS_X_WIDTH-1:0] x0;
        int n;
        send_cmd(jump_pkg::PRESS_JUMP);
        wait_ticks(MAX_CHARGE);
        send_cmd(jump_pkg::RELEASE_JUMP);
        n = 0;
        while (pos_y == 0 && n < 8 * TICK_DIV) begin
            @(negedge sys_clk);
            n++;
        end
        if (pos_y == 0) report_failure("character never left the ground");
        x0 = pos_x;
        // Each press spans one motion tick, so a step would show before the next pair
        send_cmd(jump_pkg::PRESS_LEFT);
        send_cmd(jump_pkg::RELEASE_LEFT);
        compare_value("pos_x", pos_x, x0);
        send_cmd(jump_pkg::PRESS_RIGHT);
        send_cmd(jump_pkg::RELEASE_RIGHT);
        compare_value("pos_x", pos_x, x0);
        n = 0;
        while (pos_y != 0 && n < 200 * TICK_DIV) begin
            if (pos_x != x0) begin
                compare_value("pos_x", pos_x, x0);
                break;
            end
            @(negedge sys_clk);
            n++;
        end
        wait_ticks(3);
        compare_value("pos_x", pos_x, x0);
        settle();
    endtask

    // ====================
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        errors     = 0;
        checks     = 0;
        rng_state  = 32'h7ec77e15;
        tick_prev  = 1'b0;
        charge_cnt = 0;
        right_cnt  = 0;
        left_cnt   = 0;
        tick_gap   = 0;
        tick_seen  = 1'b0;
        sys_rst_n  = 1'b0;
        cmd_req    = 1'b0;
        cmd_code   = 3'd0;
        repeat (4) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        verify_reset_state();
        handshake_and_bad_codes();
        walk_direction(1'b1);
        walk_direction(1'b0);
        charge_and_jump(2);
        charge_and_jump(MAX_CHARGE);
        charge_and_jump(MAX_CHARGE + 5);
        idle_breathing();
        air_control();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
